/* common/crPkg.sv */
// shared opcodes, register ids and widths of the control-register pipeline
// referenced by scoped name from decode, execute and the register file
`default_nettype none

package crPkg;

	// every register value and operand is this wide
	localparam int dataWidth = 64;

	// SR comes out of reset with only bit 30 set
	localparam logic [dataWidth-1:0] srResetValue = 64'h0000_0000_4000_0000;

	// instruction opcodes seen by the pipeline
	typedef enum logic [2:0]
	{
		opNop,
		opMovToCr,
		opMovFromCr,
		opOrCr,
		opAndCr
	} crOp;

	// control register ids
	// codes 8 to 14 are unassigned and behave like ZZR
	typedef enum logic [3:0]
	{
		crSr = 4'd0,
		crExsr,
		crLr,
		crVbr,
		crGbr,
		crTbr,
		crTea,
		crPc,
		crZzr = 4'd15
	} crId;

endpackage

`default_nettype wire

/* logic/crDecode.sv */
// decode stage: latches one instruction per clock, keeps the program counter
// and asks the register file for the source register
`default_nettype none

module crDecode #(
	parameter int addrWidth = 48
)
(
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic                          hold,
	input  wire crPkg::crOp                    instOp,
	input  wire crPkg::crId                    instId,
	input  wire logic [crPkg::dataWidth-1:0]   instValue,
	output crPkg::crOp                         decOp,
	output crPkg::crId                         decId,
	output logic [crPkg::dataWidth-1:0]        decValue,
	output logic [addrWidth-1:0]               decPc,
	output crPkg::crId                         readId
);

	// each real instruction is one 32-bit word
	localparam logic [addrWidth-1:0] pcStep = 4;

	logic [addrWidth-1:0] pc;

	// op and id are control state, the operand is payload
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			decOp <= crPkg::opNop;
			decId <= crPkg::crZzr;
			decPc <= '0;
			pc <= '0;
		end
		else if (!hold)
		begin
			decOp <= instOp;
			decId <= instId;
			// instruction keeps its own pc, before the advance
			decPc <= pc;
			if (instOp != crPkg::opNop)
			begin
				pc <= pc + pcStep;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			decValue <= instValue;
		end
	end

	// nop and move-to need no source, so ask for ZZR
	always_comb
	begin
		if (decOp == crPkg::opNop || decOp == crPkg::opMovToCr)
			readId = crPkg::crZzr;
		else
			readId = decId;
	end

endmodule

`default_nettype wire

/* logic/crExecute.sv */
// execute stages EX1 to EX3 for control-register instructions
// EX1 builds the write value, EX2 and EX3 carry it to write-back
`default_nettype none

module crExecute
(
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic                          hold,
	input  wire logic                          squash,
	input  wire crPkg::crOp                    decOp,
	input  wire crPkg::crId                    decId,
	input  wire logic [crPkg::dataWidth-1:0]   decValue,
	input  wire logic [crPkg::dataWidth-1:0]   readData,
	output crPkg::crId                         ex1Id,
	output logic [crPkg::dataWidth-1:0]        ex1Value,
	output crPkg::crId                         ex2Id,
	output logic [crPkg::dataWidth-1:0]        ex2Value,
	output crPkg::crId                         ex3Id,
	output logic [crPkg::dataWidth-1:0]        ex3Value,
	output logic                               readValid,
	output logic [crPkg::dataWidth-1:0]        readValue
);

	// EX1 occupant
	crPkg::crOp                   ex1Op;
	crPkg::crId                   ex1Target;
	logic [crPkg::dataWidth-1:0]  ex1Operand;
	logic [crPkg::dataWidth-1:0]  ex1Old;

	// old value travelling with the write, reported from EX3
	logic                         ex2Report;
	logic [crPkg::dataWidth-1:0]  ex2Old;

	logic ex1Live;
	logic ex1Writes;
	logic ex1Reports;

	// squash only counts on an edge that moves the pipe
	assign ex1Live = (ex1Op != crPkg::opNop) && !(squash && !hold);
	assign ex1Writes = ex1Live && (ex1Op == crPkg::opMovToCr || ex1Op == crPkg::opOrCr ||
		ex1Op == crPkg::opAndCr);
	assign ex1Reports = ex1Live && (ex1Op == crPkg::opMovFromCr || ex1Op == crPkg::opOrCr ||
		ex1Op == crPkg::opAndCr);

	// read-modify-write result, the stage id decides if it lands
	always_comb
	begin
		case (ex1Op)
			crPkg::opOrCr:  ex1Value = ex1Old | ex1Operand;
			crPkg::opAndCr: ex1Value = ex1Old & ex1Operand;
			default:        ex1Value = ex1Operand;
		endcase
	end

	// non-writers and bubbles show up as ZZR
	assign ex1Id = ex1Writes ? ex1Target : crPkg::crZzr;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ex1Op <= crPkg::opNop;
			ex1Target <= crPkg::crZzr;
			ex2Id <= crPkg::crZzr;
			ex2Report <= 1'b0;
			ex3Id <= crPkg::crZzr;
			readValid <= 1'b0;
		end
		else if (!hold)
		begin
			ex1Op <= decOp;
			ex1Target <= decId;
			ex2Id <= ex1Id;
			ex2Report <= ex1Reports;
			ex3Id <= ex2Id;
			readValid <= ex2Report;
		end
	end

	// payload, frozen with the rest on hold
	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			ex1Operand <= decValue;
			ex1Old <= readData;
			ex2Value <= ex1Value;
			ex2Old <= ex1Old;
			ex3Value <= ex2Value;
			readValue <= ex2Old;
		end
	end

endmodule

`default_nettype wire

/* regcr/crRegFile.sv */
// control register file: SR, EXSR, LR, VBR, GBR/FPSR, TBR, TEA
// combinational read with EX1..EX3 forwarding, write-back from EX3
`default_nettype none

module crRegFile #(
	parameter int addrWidth = 48
)
(
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic                          hold,
	input  wire crPkg::crId                    readId,
	input  wire logic [addrWidth-1:0]          decPc,
	input  wire crPkg::crId                    ex1Id,
	input  wire logic [crPkg::dataWidth-1:0]   ex1Value,
	input  wire crPkg::crId                    ex2Id,
	input  wire logic [crPkg::dataWidth-1:0]   ex2Value,
	input  wire crPkg::crId                    ex3Id,
	input  wire logic [crPkg::dataWidth-1:0]   ex3Value,
	output logic [crPkg::dataWidth-1:0]        readData,
	output logic [crPkg::dataWidth-1:0]        srOut,
	output logic [crPkg::dataWidth-1:0]        lrOut,
	output logic [crPkg::dataWidth-1:0]        teaOut,
	output logic [addrWidth-1:0]               vbrOut,
	output logic [addrWidth-1:0]               gbrOut,
	output logic [15:0]                        fpsrOut
);

	// upper 16 bits hold the control half of VBR and FPSR of GBR
	localparam int ctlLsb = crPkg::dataWidth - 16;
	localparam logic [crPkg::dataWidth-1:0] addrMask =
		{crPkg::dataWidth{1'b1}} >> (crPkg::dataWidth - addrWidth);
	localparam logic [crPkg::dataWidth-1:0] ctlMask = ~({crPkg::dataWidth{1'b1}} >> 16);

	logic [crPkg::dataWidth-1:0] srReg;
	logic [crPkg::dataWidth-1:0] exsrReg;
	logic [crPkg::dataWidth-1:0] lrReg;
	logic [crPkg::dataWidth-1:0] teaReg;
	logic [addrWidth-1:0]        vbrReg;
	logic [addrWidth-1:0]        gbrReg;
	logic [addrWidth-1:0]        tbrReg;
	logic [15:0]                 vbrCm;
	logic [15:0]                 fpsrReg;

	logic [crPkg::dataWidth-1:0] storedValue;
	logic                        readIsStored;

	function automatic logic [crPkg::dataWidth-1:0] ptrExt(input logic [addrWidth-1:0] p);
		return {{(crPkg::dataWidth - addrWidth){1'b0}}, p};
	endfunction

	// shape a pending write the way a read of the stored register would see it
	function automatic logic [crPkg::dataWidth-1:0] asStored(input crPkg::crId id,
		input logic [crPkg::dataWidth-1:0] v);
		case (id)
			crPkg::crVbr, crPkg::crGbr: return (v & ctlMask) | (v & addrMask);
			crPkg::crTbr:               return v & addrMask;
			default:                    return v;
		endcase
	endfunction

	assign srOut = srReg;
	assign lrOut = lrReg;
	assign teaOut = teaReg;
	assign vbrOut = vbrReg;
	assign gbrOut = gbrReg;
	assign fpsrOut = fpsrReg;

	// only real storage forwards, PC/ZZR/unassigned never do
	assign readIsStored = (readId == crPkg::crSr) || (readId == crPkg::crExsr) ||
		(readId == crPkg::crLr) || (readId == crPkg::crVbr) || (readId == crPkg::crGbr) ||
		(readId == crPkg::crTbr) || (readId == crPkg::crTea);

	always_comb
	begin
		case (readId)
			crPkg::crSr:   storedValue = srReg;
			crPkg::crExsr: storedValue = exsrReg;
			crPkg::crLr:   storedValue = lrReg;
			crPkg::crVbr:  storedValue = {vbrCm, {ctlLsb{1'b0}}} | ptrExt(vbrReg);
			crPkg::crGbr:  storedValue = {fpsrReg, {ctlLsb{1'b0}}} | ptrExt(gbrReg);
			crPkg::crTbr:  storedValue = ptrExt(tbrReg);
			crPkg::crTea:  storedValue = teaReg;
			// pc of the instruction in decode
			crPkg::crPc:   storedValue = ptrExt(decPc);
			default:       storedValue = '0;
		endcase
		readData = storedValue;
		// oldest first so EX1 ends up on top
		if (readIsStored && readId == ex3Id)
			readData = asStored(ex3Id, ex3Value);
		if (readIsStored && readId == ex2Id)
			readData = asStored(ex2Id, ex2Value);
		if (readIsStored && readId == ex1Id)
			readData = asStored(ex1Id, ex1Value);
	end

	// EX3 write-back, held with the pipe
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			srReg <= crPkg::srResetValue;
			exsrReg <= '0;
			lrReg <= '0;
			teaReg <= '0;
			vbrReg <= '0;
			gbrReg <= '0;
			tbrReg <= '0;
			vbrCm <= '0;
			fpsrReg <= '0;
		end
		else if (!hold)
		begin
			case (ex3Id)
				crPkg::crSr:   srReg <= ex3Value;
				crPkg::crExsr: exsrReg <= ex3Value;
				crPkg::crLr:   lrReg <= ex3Value;
				crPkg::crTea:  teaReg <= ex3Value;
				crPkg::crTbr:  tbrReg <= ex3Value[addrWidth-1:0];
				crPkg::crVbr:
				begin
					vbrReg <= ex3Value[addrWidth-1:0];
					vbrCm <= ex3Value[ctlLsb +: 16];
				end
				crPkg::crGbr:
				begin
					gbrReg <= ex3Value[addrWidth-1:0];
					fpsrReg <= ex3Value[ctlLsb +: 16];
				end
				// PC, ZZR and unassigned ids drop the write
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/crPipeTop.sv */
// top of the control-register pipeline: decode, EX1..EX3 and the register file
// instructions enter as level inputs, hold freezes everything
`default_nettype none

module crPipeTop #(
	parameter int addrWidth = 48
)
(
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic                          hold,
	input  wire logic                          squash,
	input  wire crPkg::crOp                    instOp,
	input  wire crPkg::crId                    instId,
	input  wire logic [crPkg::dataWidth-1:0]   instValue,
	output logic                               readValid,
	output logic [crPkg::dataWidth-1:0]        readValue,
	output logic [crPkg::dataWidth-1:0]        srOut,
	output logic [crPkg::dataWidth-1:0]        lrOut,
	output logic [crPkg::dataWidth-1:0]        teaOut,
	output logic [addrWidth-1:0]               vbrOut,
	output logic [addrWidth-1:0]               gbrOut,
	output logic [15:0]                        fpsrOut
);

	// decode outputs
	crPkg::crOp                   decOp;
	crPkg::crId                   decId;
	logic [crPkg::dataWidth-1:0]  decValue;
	logic [addrWidth-1:0]         decPc;
	crPkg::crId                   readId;
	logic [crPkg::dataWidth-1:0]  readData;

	// stage ids and values for forwarding and write-back
	crPkg::crId                   ex1Id;
	logic [crPkg::dataWidth-1:0]  ex1Value;
	crPkg::crId                   ex2Id;
	logic [crPkg::dataWidth-1:0]  ex2Value;
	crPkg::crId                   ex3Id;
	logic [crPkg::dataWidth-1:0]  ex3Value;

	crDecode #(
		.addrWidth(addrWidth)
	) decode (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.instOp(instOp),
		.instId(instId),
		.instValue(instValue),
		.decOp(decOp),
		.decId(decId),
		.decValue(decValue),
		.decPc(decPc),
		.readId(readId)
	);

	crExecute execute (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.squash(squash),
		.decOp(decOp),
		.decId(decId),
		.decValue(decValue),
		.readData(readData),
		.ex1Id(ex1Id),
		.ex1Value(ex1Value),
		.ex2Id(ex2Id),
		.ex2Value(ex2Value),
		.ex3Id(ex3Id),
		.ex3Value(ex3Value),
		.readValid(readValid),
		.readValue(readValue)
	);

	crRegFile #(
		.addrWidth(addrWidth)
	) regFile (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.readId(readId),
		.decPc(decPc),
		.ex1Id(ex1Id),
		.ex1Value(ex1Value),
		.ex2Id(ex2Id),
		.ex2Value(ex2Value),
		.ex3Id(ex3Id),
		.ex3Value(ex3Value),
		.readData(readData),
		.srOut(srOut),
		.lrOut(lrOut),
		.teaOut(teaOut),
		.vbrOut(vbrOut),
		.gbrOut(gbrOut),
		.fpsrOut(fpsrOut)
	);

endmodule

`default_nettype wire

/* bench/crModel.svh */
// cycle model of the control-register pipeline, included inside the testbench
// slot 0 is decode, slots 1 to 3 are EX1 to EX3
`ifndef crModelSvh
`define crModelSvh

	// read view, updated as an instruction leaves EX1
	logic [crPkg::dataWidth-1:0] archRegs [0:15];
	// what the register outputs show, updated at write-back
	logic [crPkg::dataWidth-1:0] outRegs [0:15];
	logic                        slotValid [0:3];
	crPkg::crOp                  slotOp [0:3];
	crPkg::crId                  slotId [0:3];
	logic [crPkg::dataWidth-1:0] slotValue [0:3];
	logic [crPkg::dataWidth-1:0] slotOld [0:3];
	logic [addrWidth-1:0]        slotPc [0:3];
	logic [addrWidth-1:0]        modelPc;

	function automatic logic writesReg(input crPkg::crOp op);
		return op == crPkg::opMovToCr || op == crPkg::opOrCr || op == crPkg::opAndCr;
	endfunction

	function automatic logic reportsOld(input crPkg::crOp op);
		return op == crPkg::opMovFromCr || op == crPkg::opOrCr || op == crPkg::opAndCr;
	endfunction

	// SR up to TEA, PC is not storage
	function automatic logic isStorage(input crPkg::crId id);
		return id < crPkg::crPc;
	endfunction

	// value a later read returns after writing v
	function automatic logic [crPkg::dataWidth-1:0] shapeWrite(input crPkg::crId id,
		input logic [crPkg::dataWidth-1:0] v);
		logic [crPkg::dataWidth-1:0] r;
		int top;
		r = v;
		// VBR and GBR keep their top 16 bits, TBR keeps nothing above the pointer
		top = (id == crPkg::crTbr) ? crPkg::dataWidth : crPkg::dataWidth - 16;
		if (id == crPkg::crVbr || id == crPkg::crGbr || id == crPkg::crTbr)
		begin
			for (int b = addrWidth; b < top; b++)
				r[b] = 1'b0;
		end
		return r;
	endfunction

	function automatic logic [crPkg::dataWidth-1:0] modelRead(input crPkg::crId id,
		input logic [addrWidth-1:0] pc);
		if (id == crPkg::crPc)
			return crPkg::dataWidth'(pc);
		return isStorage(id) ? archRegs[id] : '0;
	endfunction

	task automatic modelReset();
		for (int i = 0; i < 16; i++)
		begin
			archRegs[i] = '0;
			outRegs[i] = '0;
		end
		archRegs[crPkg::crSr] = crPkg::srResetValue;
		outRegs[crPkg::crSr] = crPkg::srResetValue;
		for (int s = 0; s < 4; s++)
		begin
			slotValid[s] = 1'b0;
			slotOp[s] = crPkg::opNop;
		end
		modelPc = '0;
	endtask

	// one clock edge with reset and hold low
	task automatic modelStep(input crPkg::crOp op, input crPkg::crId id,
		input logic [crPkg::dataWidth-1:0] value, input logic squashIn);
		if (slotValid[3] && writesReg(slotOp[3]) && isStorage(slotId[3]))
			outRegs[slotId[3]] = shapeWrite(slotId[3], slotValue[3]);
		// squashed occupant never reads, writes or reports
		if (squashIn)
			slotValid[1] = 1'b0;
		if (slotValid[1])
		begin
			slotOld[1] = modelRead(slotId[1], slotPc[1]);
			if (slotOp[1] == crPkg::opOrCr)
				slotValue[1] = slotOld[1] | slotValue[1];
			else if (slotOp[1] == crPkg::opAndCr)
				slotValue[1] = slotOld[1] & slotValue[1];
			if (writesReg(slotOp[1]) && isStorage(slotId[1]))
				archRegs[slotId[1]] = shapeWrite(slotId[1], slotValue[1]);
		end
		for (int s = 3; s > 0; s--)
		begin
			slotValid[s] = slotValid[s - 1];
			slotOp[s] = slotOp[s - 1];
			slotId[s] = slotId[s - 1];
			slotValue[s] = slotValue[s - 1];
			slotOld[s] = slotOld[s - 1];
			slotPc[s] = slotPc[s - 1];
		end
		slotValid[0] = op != crPkg::opNop;
		slotOp[0] = op;
		slotId[0] = id;
		slotValue[0] = value;
		slotPc[0] = modelPc;
		// pc moves on past every real instruction
		if (slotValid[0])
			modelPc = modelPc + addrWidth'(4);
	endtask

`endif

/* bench/crPipeTb.sv */
// testbench for crPipeTop with a seeded random instruction stream
// every output is checked each cycle against the cycle model
`default_nettype none

module crPipeTb;

	// same as the crPipeTop default
	localparam int addrWidth = 48;
	localparam int testCount = 6;
	localparam int testCycles = 300;
	localparam int drainCycles = 8;
	// reset, all tests, the drain and some slack
	localparam int timeoutLimit = 3 + testCount * testCycles + drainCycles + 50;

	logic                        clock;
	logic                        reset;
	logic                        hold;
	logic                        squash;
	crPkg::crOp                  instOp;
	crPkg::crId                  instId;
	logic [crPkg::dataWidth-1:0] instValue;
	logic                        readValid;
	logic [crPkg::dataWidth-1:0] readValue;
	logic [crPkg::dataWidth-1:0] srOut;
	logic [crPkg::dataWidth-1:0] lrOut;
	logic [crPkg::dataWidth-1:0] teaOut;
	logic [addrWidth-1:0]        vbrOut;
	logic [addrWidth-1:0]        gbrOut;
	logic [15:0]                 fpsrOut;

	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors;

	`include "crModel.svh"

	crPipeTop #(.addrWidth(addrWidth)) i_dut (.*);

	always #50 clock = ~clock;

	// model follows the same edges as the DUT
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (reset)
			modelReset();
		else if (!hold)
			modelStep(instOp, instId, instValue, squash);
	end

	task automatic checkData(input string what, input logic [crPkg::dataWidth-1:0] got,
		input logic [crPkg::dataWidth-1:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkAddr(input string what, input logic [addrWidth-1:0] got,
		input logic [addrWidth-1:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkHalf(input string what, input logic [15:0] got,
		input logic [15:0] expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic expected);
		checkCount++;
		if (got !== expected)
		begin
			errorCount++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic checkOutputs();
		checkFlag("readValid", readValid, slotValid[3] && reportsOld(slotOp[3]));
		// readValue only matters while a report is due
		if (slotValid[3] && reportsOld(slotOp[3]))
			checkData("readValue", readValue, slotOld[3]);
		checkData("srOut", srOut, outRegs[crPkg::crSr]);
		checkData("lrOut", lrOut, outRegs[crPkg::crLr]);
		checkData("teaOut", teaOut, outRegs[crPkg::crTea]);
		checkAddr("vbrOut", vbrOut, outRegs[crPkg::crVbr][addrWidth-1:0]);
		checkAddr("gbrOut", gbrOut, outRegs[crPkg::crGbr][addrWidth-1:0]);
		checkHalf("fpsrOut", fpsrOut, outRegs[crPkg::crGbr][crPkg::dataWidth-1 -: 16]);
	endtask

	function automatic crPkg::crOp pickOp(input int test);
		int r;
		r = $urandom % 8;
		case (test)
			// mostly idle with a few reads
			0: return (r < 6) ? crPkg::opNop : crPkg::opMovFromCr;
			1: return (r < 4) ? crPkg::opMovToCr : crPkg::opMovFromCr;
			// no nops so read-modify-write ops sit back to back
			2: return crPkg::crOp'(3'(1 + r % 4));
			3, 4, 5: return crPkg::crOp'(3'(r % 5));
			default: return crPkg::opNop;
		endcase
	endfunction

	function automatic crPkg::crId pickId(input int test);
		int r;
		r = $urandom % 16;
		case (test)
			// three ids only so neighbours depend on each other
			1: return crPkg::crId'(4'(r % 3));
			// VBR, GBR and TBR for packing and truncation
			2: return crPkg::crId'(4'(3 + r % 3));
			// any code including PC, ZZR and the unassigned ones
			3: return crPkg::crId'(4'(r));
			default: return crPkg::crId'(4'((r < 12) ? r % 8 : r));
		endcase
	endfunction

	function automatic string testName(input int test);
		case (test)
			0: return "reset and idle";
			1: return "move to and from";
			2: return "or, and, packing";
			3: return "pc, zzr, unassigned";
			4: return "squash";
			default: return "hold";
		endcase
	endfunction

	task automatic driveNext(input int test);
		// a held instruction was not taken and stays on the inputs
		if (!hold)
		begin
			instOp <= pickOp(test);
			instId <= pickId(test);
			instValue <= {$urandom, $urandom};
		end
		squash <= (test == 4 || test == 5) && ($urandom % 5 == 0);
		hold <= (test == 5) && ($urandom % 3 == 0);
	endtask

	task automatic runCycle(input int test);
		@(posedge clock);
		driveNext(test);
		@(negedge clock);
		checkOutputs();
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		hold = 1'b0;
		squash = 1'b0;
		instOp = crPkg::opNop;
		instId = crPkg::crZzr;
		instValue = '0;
		void'($urandom(19));
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		for (int test = 0; test < testCount; test++)
		begin
			testErrors = errorCount;
			repeat (testCycles) runCycle(test);
			$display("test %0d (%s): %0d errors", test, testName(test), errorCount - testErrors);
		end
		// nops until the last instructions are written back
		repeat (drainCycles) runCycle(testCount);
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		wait (cycleCount >= timeoutLimit);
		$display("timeout: the run did not end within %0d cycles", timeoutLimit);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
common/crPkg.sv
logic/crDecode.sv
logic/crExecute.sv
regcr/crRegFile.sv
logic/crPipeTop.sv
bench/crPipeTb.sv

/* Makefile */
# Verilator build and run of the control-register pipeline testbench
SIM      = verilator
FLAGS    = --binary -j 0
TOP      = crPipeTb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard bench/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BUILD)/V%: $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
